/* src/flux_drive_pkg.sv */
`default_nettype none

package flux_drive_pkg;

    // ====================
    // Widths
    // ====================
    typedef logic [6:0]  track_t;       // Head track 0..79
    typedef logic [16:0] bit_pos_t;     // Bit index within track
    typedef logic [13:0] byte_addr_t;   // Byte address in track buffer
    typedef logic [5:0]  cell_timer_t;  // Bit-cell countdown
    typedef logic [3:0]  sense_reg_t;   // {head_sel, latched_reg}

    // ====================
    // Geometry and timing
    // ====================
    localparam track_t      MAX_TRACK        = 7'd79;  // 80 tracks on a 3.5" disk
    localparam cell_timer_t BIT_CELL_CYCLES  = 6'd28;  // 2 us cell at 14 MHz
    localparam logic [1:0]  SPINUP_ROTATIONS = 2'd2;   // Rotations before ready

    // Sony command codes, head_sel low
    localparam sense_reg_t CMD_DIR_IN    = 4'd0;  // Step toward higher tracks
    localparam sense_reg_t CMD_MOTOR_ON  = 4'd2;
    localparam sense_reg_t CMD_DIR_OUT   = 4'd4;  // Step toward track 0
    localparam sense_reg_t CMD_MOTOR_OFF = 4'd6;

    // ====================
    // Structs
    // ====================
    typedef struct packed {
        logic disk_mounted;
        logic disk_wp;      // 1 = protected
    } drive_cfg_t;

    typedef struct packed {
        logic step_dir;       // 1 = toward track 0
        logic sony_motor_on;  // Motor state from Sony commands
    } cmd_state_t;

    typedef struct packed {
        logic motor_spinning;
        logic drive_ready;
    } spin_state_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic       cyc;
        logic       stb;
        byte_addr_t adr;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // ====================
    // State machines
    // ====================
    typedef enum logic [1:0] {SPIN_STOPPED, SPIN_UP, SPIN_READY} spindle_state_e;
    typedef enum logic {FETCH_IDLE, FETCH_WAIT} fetch_state_e;

endpackage

`default_nettype wire

/* src/sony_cmd_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module sony_cmd_decode (
    input  wire                        CLK_14M,
    input  wire                        RESET,
    input  wire [3:0]                  phases,       // PH3 is the command strobe
    input  wire [2:0]                  latched_reg,
    input  wire                        head_sel,
    input  flux_drive_pkg::drive_cfg_t cfg,
    output flux_drive_pkg::cmd_state_t cmd
);

    logic                       strobe_q;     // Previous PH3 level
    logic                       strobe_edge;
    flux_drive_pkg::sense_reg_t cmd_reg;
    flux_drive_pkg::cmd_state_t cmd_q;

    assign strobe_edge = phases[3] & ~strobe_q;  // Rising edge on PH3
    assign cmd_reg     = {head_sel, latched_reg}; // Side 1 pushes codes to 8..15

    // ====================
    // Strobe and command registers
    // ====================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            strobe_q <= 1'b0;
            cmd_q    <= '0;  // Toward higher tracks, motor off
        end else begin
            strobe_q <= phases[3];
            if (strobe_edge) begin
                case (cmd_reg)
                    flux_drive_pkg::CMD_DIR_IN:    cmd_q.step_dir <= 1'b0;
                    flux_drive_pkg::CMD_DIR_OUT:   cmd_q.step_dir <= 1'b1;
                    flux_drive_pkg::CMD_MOTOR_ON: begin
                        // No spindle without a disk in place
                        if (cfg.disk_mounted)
                            cmd_q.sony_motor_on <= 1'b1;
                    end
                    flux_drive_pkg::CMD_MOTOR_OFF: cmd_q.sony_motor_on <= 1'b0;
                    default: ;  // Other codes and side 1 do nothing
                endcase
            end
        end
    end

    assign cmd = cmd_q;

    // Command state only moves on a strobe edge
    property p_cmd_on_strobe;
        @(posedge CLK_14M) disable iff (RESET)
        !strobe_edge |=> $stable(cmd_q);
    endproperty

    a_cmd_on_strobe: assert property (p_cmd_on_strobe)
        else $error("cmd changed without a strobe edge");

endmodule

`default_nettype wire

/* src/head_stepper.sv */
`timescale 1ns/100ps
`default_nettype none

module head_stepper (
    input  wire                         CLK_14M,
    input  wire                         RESET,
    input  wire [3:0]                   phases,  // CA0 = direction, CA1 = step
    input  flux_drive_pkg::spin_state_t spin,
    output flux_drive_pkg::track_t      track
);

    logic                   ca1_q;    // Previous CA1 level
    logic                   step_now;
    flux_drive_pkg::track_t track_q;

    // Falling CA1 steps, only with the motor turning
    assign step_now = ca1_q & ~phases[1] & spin.motor_spinning;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            ca1_q   <= 1'b0;
            track_q <= '0;
        end else begin
            ca1_q <= phases[1];
            if (step_now) begin
                if (phases[0]) begin
                    if (track_q < flux_drive_pkg::MAX_TRACK)
                        track_q <= track_q + 7'd1;  // Inward
                end else if (track_q != '0) begin
                    track_q <= track_q - 7'd1;      // Outward, stop at 0
                end
            end
        end
    end

    assign track = track_q;

    // Head stays on the disk and moves one track at a time
    property p_track_step;
        @(posedge CLK_14M) disable iff (RESET)
        1'b1 |=> (track_q <= flux_drive_pkg::MAX_TRACK) &&
                 ((track_q == $past(track_q)) ||
                  (track_q == $past(track_q) + 7'd1) ||
                  (track_q == $past(track_q) - 7'd1));
    endproperty

    a_track_step: assert property (p_track_step)
        else $error("track out of range or jumped");

endmodule

`default_nettype wire

/* src/disk_spindle.sv */
`timescale 1ns/100ps
`default_nettype none

module disk_spindle (
    input  wire                         CLK_14M,
    input  wire                         RESET,
    input  wire                         sw_motor_on,
    input  flux_drive_pkg::cmd_state_t  cmd,
    input  flux_drive_pkg::drive_cfg_t  cfg,
    input  flux_drive_pkg::bit_pos_t    track_bit_count,
    input  wire                         track_loaded,
    output flux_drive_pkg::wb_req_t     wb_req,
    input  flux_drive_pkg::wb_rsp_t     wb_rsp,
    output flux_drive_pkg::spin_state_t spin,
    output wire                         flux
);

    flux_drive_pkg::spindle_state_e spin_state;
    flux_drive_pkg::fetch_state_e   fetch_state;
    flux_drive_pkg::wb_req_t        req_q;
    flux_drive_pkg::bit_pos_t       bit_pos, next_pos;
    flux_drive_pkg::cell_timer_t    timer;
    flux_drive_pkg::byte_addr_t     want_adr;
    logic        motor_q;
    logic [1:0]  rot_cnt;           // Wraps seen during spin-up
    logic [17:0] pos_inc;
    logic [7:0]  cur_byte, nxt_byte; // Byte in use, prefetched byte
    logic        cur_valid, nxt_valid;
    logic        cell_first;        // First cycle of a cell
    logic        last_bit, need_fetch, fill;
    logic        start_first, cell_end, advance_bit, load_cur, rot_tick;

    // ====================
    // Rotation decode
    // ====================
    assign pos_inc  = {1'b0, bit_pos} + 18'd1;
    assign next_pos = (pos_inc >= {1'b0, track_bit_count}) ? '0 : pos_inc[16:0];
    assign last_bit = (next_pos[2:0] == 3'd0);  // Also true at the track wrap

    // Byte 0 at start, else the byte after the current one
    assign want_adr   = cur_valid ? next_pos[16:3] : bit_pos[16:3];
    assign need_fetch = motor_q & ~nxt_valid & (~cur_valid | last_bit);
    assign fill       = (fetch_state == flux_drive_pkg::FETCH_WAIT) & wb_rsp.ack &
                        need_fetch & (req_q.adr == want_adr);  // Drop stale reads

    assign start_first = motor_q & ~cur_valid & nxt_valid & track_loaded;
    assign cell_end    = motor_q & cur_valid & track_loaded & (timer == 6'd1);
    assign advance_bit = cell_end & (~last_bit | nxt_valid);  // Late byte stalls here
    assign load_cur    = start_first | (advance_bit & last_bit);
    assign rot_tick    = advance_bit & (next_pos == '0);

    // Motor and spin-up FSM
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            motor_q    <= 1'b0;
            spin_state <= flux_drive_pkg::SPIN_STOPPED;
            rot_cnt    <= 2'd0;
        end else begin
            motor_q <= sw_motor_on | cmd.sony_motor_on;
            if (!motor_q) begin
                spin_state <= flux_drive_pkg::SPIN_STOPPED;  // Ready drops here
                rot_cnt    <= 2'd0;
            end else begin
                case (spin_state)
                    flux_drive_pkg::SPIN_STOPPED:
                        if (cfg.disk_mounted)
                            spin_state <= flux_drive_pkg::SPIN_UP;
                    flux_drive_pkg::SPIN_UP:
                        if (rot_tick) begin
                            if (rot_cnt == flux_drive_pkg::SPINUP_ROTATIONS - 2'd1)
                                spin_state <= flux_drive_pkg::SPIN_READY;
                            else
                                rot_cnt <= rot_cnt + 2'd1;
                        end
                    default: ;  // Ready until the motor stops
                endcase
            end
        end
    end

    // Cell timer and bit position
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            bit_pos    <= '0;
            timer      <= flux_drive_pkg::BIT_CELL_CYCLES;
            cur_valid  <= 1'b0;
            nxt_valid  <= 1'b0;
            cell_first <= 1'b0;
        end else if (!motor_q) begin
            bit_pos    <= '0;  // Rotation restarts at bit 0
            timer      <= flux_drive_pkg::BIT_CELL_CYCLES;
            cur_valid  <= 1'b0;
            nxt_valid  <= 1'b0;
            cell_first <= 1'b0;
        end else begin
            cell_first <= start_first | advance_bit;
            if (fill)
                nxt_valid <= 1'b1;
            else if (load_cur)
                nxt_valid <= 1'b0;
            if (start_first) begin
                cur_valid <= 1'b1;
                timer     <= flux_drive_pkg::BIT_CELL_CYCLES;
            end else if (advance_bit) begin
                bit_pos <= next_pos;
                timer   <= flux_drive_pkg::BIT_CELL_CYCLES;
            end else if (cur_valid && track_loaded && timer != 6'd1) begin
                timer <= timer - 6'd1;
            end
        end
    end

    // Track bytes
    always_ff @(posedge CLK_14M) begin
        if (fill)
            nxt_byte <= wb_rsp.dat;
        if (load_cur)
            cur_byte <= nxt_byte;
    end

    // Wishbone fetch FSM, one read at a time
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            fetch_state <= flux_drive_pkg::FETCH_IDLE;
            req_q       <= '0;
        end else begin
            case (fetch_state)
                flux_drive_pkg::FETCH_IDLE:
                    if (need_fetch) begin
                        req_q.cyc   <= 1'b1;
                        req_q.stb   <= 1'b1;
                        req_q.adr   <= want_adr;
                        fetch_state <= flux_drive_pkg::FETCH_WAIT;
                    end
                default:
                    if (wb_rsp.ack) begin  // Bus drops the cycle after ack
                        req_q.cyc   <= 1'b0;
                        req_q.stb   <= 1'b0;
                        fetch_state <= flux_drive_pkg::FETCH_IDLE;
                    end
            endcase
        end
    end

    assign wb_req = req_q;
    assign spin   = '{motor_spinning: motor_q,
                      drive_ready:    spin_state == flux_drive_pkg::SPIN_READY};
    // MSB first within the byte
    assign flux   = cell_first & cur_byte[3'd7 - bit_pos[2:0]] & spin.drive_ready & motor_q;

    a_stb_cyc: assert property (@(posedge CLK_14M) disable iff (RESET)
        wb_req.stb |-> wb_req.cyc)
        else $error("stb without cyc");

    a_adr_hold: assert property (@(posedge CLK_14M) disable iff (RESET)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
        else $error("adr or stb moved while a read waits");

    a_flux_ready: assert property (@(posedge CLK_14M) disable iff (RESET)
        flux |-> spin.drive_ready)
        else $error("flux before drive ready");

endmodule

`default_nettype wire

/* src/status_sense.sv */
`timescale 1ns/100ps
`default_nettype none

module status_sense (
    input  wire                         head_sel,
    input  wire [2:0]                   latched_reg,
    input  flux_drive_pkg::cmd_state_t  cmd,
    input  flux_drive_pkg::spin_state_t spin,
    input  flux_drive_pkg::track_t      track,
    input  flux_drive_pkg::drive_cfg_t  cfg,
    output logic                        sense
);

    flux_drive_pkg::sense_reg_t status_reg;

    assign status_reg = {head_sel, latched_reg};

    // Most lines are active low
    always_comb begin
        case (status_reg)
            4'h0: sense = cmd.step_dir;         // Step direction
            4'h1: sense = 1'b1;                 // Step done
            4'h2: sense = ~cmd.sony_motor_on;   // Motor, 0 = on
            4'h3: sense = 1'b1;                 // No disk change
            4'h4: sense = 1'b0;
            4'h5: sense = 1'b0;                 // Not MFM capable
            4'h6: sense = 1'b1;                 // Double sided
            4'h7: sense = 1'b0;                 // Drive present
            4'h8: sense = ~cfg.disk_mounted;    // Disk in place
            4'h9: sense = ~cfg.disk_wp;         // 0 = protected
            4'hA: sense = (track != '0);        // 0 at track 0
            4'hB: sense = 1'b1;                 // Tach
            4'hC: sense = 1'b0;
            4'hD: sense = 1'b0;                 // GCR mode
            4'hE: sense = ~spin.drive_ready;    // 0 = ready
            default: sense = 1'b1;              // 800K interface
        endcase
    end

endmodule

`default_nettype wire

/* src/flux_drive_top.sv */
`timescale 1ns/100ps
`default_nettype none

module flux_drive_top (
    input  wire                         CLK_14M,
    input  wire                         RESET,
    input  wire [3:0]                   phases,
    input  wire [2:0]                   latched_reg,
    input  wire                         head_sel,
    input  wire                         sw_motor_on,
    input  flux_drive_pkg::drive_cfg_t  cfg,
    input  flux_drive_pkg::bit_pos_t    track_bit_count,
    input  wire                         track_loaded,
    input  flux_drive_pkg::wb_rsp_t     wb_rsp,
    output flux_drive_pkg::wb_req_t     wb_req,
    output wire                         flux,
    output wire                         sense,
    output flux_drive_pkg::track_t      track,
    output wire                         motor_spinning,
    output wire                         drive_ready
);

    flux_drive_pkg::cmd_state_t  cmd;   // Decode to spindle and sense
    flux_drive_pkg::spin_state_t spin;  // Spindle to stepper and sense

    // ====================
    // Stages
    // ====================
    sony_cmd_decode u_cmd (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .phases     (phases),
        .latched_reg(latched_reg),
        .head_sel   (head_sel),
        .cfg        (cfg),
        .cmd        (cmd)
    );

    head_stepper u_step (
        .CLK_14M(CLK_14M),
        .RESET  (RESET),
        .phases (phases),
        .spin   (spin),
        .track  (track)
    );

    disk_spindle u_spindle (
        .CLK_14M        (CLK_14M),
        .RESET          (RESET),
        .sw_motor_on    (sw_motor_on),
        .cmd            (cmd),
        .cfg            (cfg),
        .track_bit_count(track_bit_count),
        .track_loaded   (track_loaded),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .spin           (spin),
        .flux           (flux)
    );

    status_sense u_sense (
        .head_sel   (head_sel),
        .latched_reg(latched_reg),
        .cmd        (cmd),
        .spin       (spin),
        .track      (track),
        .cfg        (cfg),
        .sense      (sense)
    );

    assign motor_spinning = spin.motor_spinning;
    assign drive_ready    = spin.drive_ready;

endmodule

`default_nettype wire

/* verification/flux_drive_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module flux_drive_tb;

    localparam int BITS       = 40;               // Track length under test
    localparam int ROT_CYCLES = BITS * 28;        // One rotation in clocks
    localparam int TEST_CYCLES = 1500 + 5 * ROT_CYCLES + 4000;  // Sum of test lengths

    logic CLK_14M = 1'b0, RESET = 1'b1;
    logic [3:0] phases;
    logic [2:0] latched_reg;
    logic       head_sel, sw_motor_on, track_loaded, sense, flux, motor_spinning, drive_ready;
    flux_drive_pkg::drive_cfg_t  cfg;
    flux_drive_pkg::bit_pos_t    track_bit_count;
    flux_drive_pkg::wb_req_t     wb_req;
    flux_drive_pkg::wb_rsp_t     wb_rsp;
    flux_drive_pkg::track_t      track;

    integer     seed = 22984, errors = 0, tests = 0, errs_at_start = 0;
    logic [7:0] mem [0:63];                       // Track buffer contents
    integer     wait_cnt = 0, delay = 0;
    logic       stall = 1'b0;
    logic       exp_dir = 1'b0, exp_motor = 1'b0; // Command state model
    integer     exp_track = 0;
    integer     cyc_no = 0, spin_rise = 0, cell_start = 0, bit_idx = 0, ack_at = 0;
    integer     exp_adr = 0, cells = 0, stall_hits = 0;
    logic       ack_seen = 1'b0, ready_q = 1'b0, motor_q = 1'b0, stb_q = 1'b0;

    flux_drive_top uut (.*);

    always #4 CLK_14M = ~CLK_14M;  // 8 ns period

    task automatic note_failure(input string msg);
        errors = errors + 1;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("%s finished with %0d errors", name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    // Head after one step with saturation at both ends
    function automatic integer step_result(input integer t, input logic up);
        if (up) return (t < 79) ? t + 1 : t;
        return (t > 0) ? t - 1 : t;
    endfunction

    function automatic logic bit_of(input integer idx);  // MSB first
        return mem[idx / 8][7 - (idx % 8)];
    endfunction

    function automatic logic expected_sense(input logic [3:0] r);
        case (r)
            4'h0: return exp_dir;
            4'h2: return ~exp_motor;
            4'h1, 4'h3, 4'h6, 4'hB, 4'hF: return 1'b1;
            4'h8: return ~cfg.disk_mounted;
            4'h9: return ~cfg.disk_wp;
            4'hA: return exp_track != 0;
            4'hE: return 1'b1;                    // Never ready in these tests
            default: return 1'b0;
        endcase
    endfunction

    // ====================
    // Track buffer model
    // ====================
    always @(posedge CLK_14M) begin
        if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;                   // One-cycle ack
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_cnt >= (stall ? 40 : delay)) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[wb_req.adr[5:0]];
                wait_cnt   <= 0;
                delay      <= {$random(seed)} % 4;  // 0..3 cycles
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    task automatic send_cmd(input logic [3:0] code);
        @(posedge CLK_14M);
        head_sel <= code[3];
        latched_reg <= code[2:0];
        phases[3] <= 1'b1;                        // Strobe
        @(posedge CLK_14M);
        phases[3] <= 1'b0;
        @(posedge CLK_14M);
        if (!code[3]) begin
            case (code[2:0])
                3'd0: exp_dir = 1'b0;
                3'd4: exp_dir = 1'b1;
                3'd2: if (cfg.disk_mounted) exp_motor = 1'b1;
                3'd6: exp_motor = 1'b0;
                default: ;
            endcase
        end
    endtask

    task automatic check_sense(input logic [3:0] r);
        @(posedge CLK_14M);
        head_sel <= r[3];
        latched_reg <= r[2:0];
        @(negedge CLK_14M);
        assert (sense == expected_sense(r)) else note_failure($sformatf("sense reg %h", r));
    endtask

    task automatic step(input logic up);
        @(posedge CLK_14M);
        phases[0] <= up;
        phases[1] <= 1'b1;
        @(posedge CLK_14M);
        phases[1] <= 1'b0;                        // CA1 falls
        @(posedge CLK_14M);
        if (motor_q) exp_track = step_result(exp_track, up);
        @(negedge CLK_14M);
        assert (track == exp_track) else note_failure("track after step");
    endtask

    task automatic set_motor(input logic on);
        integer n;
        n = 0;
        @(posedge CLK_14M);
        sw_motor_on <= on;
        while (motor_spinning != on && n < 20) begin
            @(negedge CLK_14M);
            n = n + 1;
        end
        if (motor_spinning != on) note_failure("motor_spinning did not follow sw_motor_on");
        repeat (50) @(posedge CLK_14M);           // Let any open read finish
    endtask

    // ====================
    // Cell and bus monitor
    // ====================
    always @(negedge CLK_14M) begin
        cyc_no = cyc_no + 1;
        if (!RESET) begin
            if (motor_spinning && !motor_q) begin
                spin_rise = cyc_no;
                exp_adr = 0;
            end
            if (wb_req.stb && !stb_q) begin       // New read with bytes wrapping at 5
                assert (wb_req.adr == exp_adr) else note_failure("read address out of order");
                exp_adr = (exp_adr == BITS / 8 - 1) ? 0 : exp_adr + 1;
            end
            if (drive_ready && !ready_q) begin    // First cell of bit 0
                assert (cyc_no - spin_rise >= 2 * ROT_CYCLES) else note_failure("ready too early");
                cell_start = cyc_no;
                bit_idx = 0;
                ack_seen = 1'b0;
                assert (flux == bit_of(0)) else note_failure("flux at bit 0");
            end else if (drive_ready && motor_spinning) begin
                if (wb_rsp.ack && bit_idx % 8 == 7) begin
                    ack_seen = 1'b1;
                    ack_at = cyc_no;
                end
                if (cyc_no >= cell_start + 28 &&
                    (bit_idx % 8 != 7 || (ack_seen && cyc_no >= ack_at + 2))) begin
                    if (cyc_no > cell_start + 28) stall_hits = stall_hits + 1;
                    bit_idx = (bit_idx + 1) % BITS;
                    cell_start = cyc_no;
                    ack_seen = 1'b0;
                    cells = cells + 1;
                    assert (flux == bit_of(bit_idx)) else note_failure("flux bit mismatch");
                end else begin
                    assert (!flux) else note_failure("flux inside a cell");
                end
            end
        end
        ready_q = drive_ready;
        motor_q = motor_spinning;
        stb_q = wb_req.stb;
    end

    a_reset_idle: assert property (@(posedge CLK_14M) RESET |-> (!flux && !drive_ready &&
        !motor_spinning && !wb_req.cyc && !wb_req.stb && track == 0))
        else note_failure("outputs not idle in reset");
    a_motor_on: assert property (@(posedge CLK_14M) disable iff (RESET)
        ($rose(phases[3]) && !head_sel && latched_reg == 3'd2 && cfg.disk_mounted) |=> !sense)
        else note_failure("motor on not seen one cycle after strobe");
    a_step: assert property (@(posedge CLK_14M) disable iff (RESET)
        ($fell(phases[1]) && motor_spinning) |=>
        track == step_result($past(track), $past(phases[0])))
        else note_failure("track step wrong");
    a_no_step: assert property (@(posedge CLK_14M) disable iff (RESET)
        ($fell(phases[1]) && !motor_spinning) |=> $stable(track))
        else note_failure("track moved with motor stopped");
    a_flux_ready: assert property (@(posedge CLK_14M) disable iff (RESET) flux |-> drive_ready)
        else note_failure("flux while not ready");
    a_no_flux_stall: assert property (@(posedge CLK_14M) disable iff (RESET)
        (wb_req.stb && !wb_rsp.ack) |-> !flux)
        else note_failure("flux while a read waits");

    initial begin  // Watchdog
        #(2 * TEST_CYCLES * 8);
        $display("Watchdog expired before the tests completed");
        $display("test failed");
        $finish;
    end

    initial begin
        integer i, n;
        for (i = 0; i < 64; i = i + 1) mem[i] = $random(seed);
        phases = 4'd0;
        latched_reg = 3'd0;
        head_sel = 1'b0;
        sw_motor_on = 1'b0;
        cfg = '{disk_mounted: 1'b1, disk_wp: 1'b0};
        track_bit_count = BITS;
        track_loaded = 1'b1;
        wb_rsp = '0;
        // Two reset cycles
        @(negedge CLK_14M);
        assert (sense == 1'b0) else note_failure("reg 0 sense in reset");
        @(posedge CLK_14M);
        latched_reg <= 3'd2;
        @(negedge CLK_14M);
        assert (sense == 1'b1) else note_failure("reg 2 sense in reset");
        @(posedge CLK_14M);
        RESET <= 1'b0;
        @(posedge CLK_14M);
        @(negedge CLK_14M);
        assert (!flux && !drive_ready && !motor_spinning && !wb_req.cyc && !wb_req.stb &&
                track == 0 && sense)
            else note_failure("outputs not idle after reset");
        end_test("reset");
        // Sense table over cfg and command state
        for (i = 0; i < 16; i = i + 1) begin
            @(posedge CLK_14M);
            cfg <= flux_drive_pkg::drive_cfg_t'(i[3:2]);
            send_cmd(i[0] ? flux_drive_pkg::CMD_DIR_OUT : flux_drive_pkg::CMD_DIR_IN);
            send_cmd(i[1] ? flux_drive_pkg::CMD_MOTOR_ON : flux_drive_pkg::CMD_MOTOR_OFF);
            for (n = 0; n < 16; n = n + 1) check_sense(n[3:0]);
        end
        send_cmd(flux_drive_pkg::CMD_MOTOR_OFF);
        end_test("sense table");
        // Commands
        cfg <= '{disk_mounted: 1'b0, disk_wp: 1'b0};
        send_cmd(flux_drive_pkg::CMD_MOTOR_ON);   // Ignored with no disk
        check_sense(4'h2);
        @(posedge CLK_14M);
        cfg <= '{disk_mounted: 1'b1, disk_wp: 1'b0};
        send_cmd(flux_drive_pkg::CMD_MOTOR_ON);
        check_sense(4'h2);
        send_cmd(flux_drive_pkg::CMD_MOTOR_OFF);
        check_sense(4'h2);
        send_cmd(flux_drive_pkg::CMD_DIR_OUT);
        check_sense(4'h0);
        send_cmd(flux_drive_pkg::CMD_DIR_IN);
        check_sense(4'h0);
        for (i = 8; i < 16; i = i + 1) begin
            send_cmd(i[3:0]);                     // Side 1 codes change nothing
            check_sense(4'h0);
            check_sense(4'h2);
        end
        end_test("commands");
        // Stepping
        set_motor(1'b1);
        repeat (3) step(1'b1);
        repeat (5) step(1'b0);                    // Saturates at 0
        repeat (82) step(1'b1);                   // Saturates at 79
        set_motor(1'b0);
        repeat (2) step(1'b0);
        end_test("stepping");
        // Spin-up and flux
        set_motor(1'b1);
        n = 0;
        while (!drive_ready && n < 3 * ROT_CYCLES) begin
            @(negedge CLK_14M);
            n = n + 1;
        end
        if (!drive_ready) note_failure("drive_ready never rose");
        cells = 0;
        repeat (3 * ROT_CYCLES) @(posedge CLK_14M);
        if (cells < 3 * BITS - 1) note_failure("too few bit cells after ready");
        end_test("spin-up and flux");
        // Slow track buffer
        stall <= 1'b1;
        stall_hits = 0;
        repeat (4000) @(posedge CLK_14M);
        if (stall_hits == 0) note_failure("slow reads never stretched a cell");
        stall <= 1'b0;
        set_motor(1'b0);
        end_test("wishbone stall");
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/flux_drive_pkg.sv
src/sony_cmd_decode.sv
src/head_stepper.sv
src/disk_spindle.sv
src/status_sense.sv
src/flux_drive_top.sv
verification/flux_drive_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flux drive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module flux_drive_tb \
    -f filelist.f \
    --Mdir obj_dir -o flux_drive_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/flux_drive_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
